//--- list.f
source/lrq_pkg.sv
source/lrq_entry.sv
source/lrq_alloc.sv
source/lrq_oldest_pick.sv
source/lrq_fill.sv
source/l1d_load_requester.sv
dv/tb_l1d_load_requester.sv

//--- Makefile
SHELL  := /bin/bash
TB_TOP := tb_l1d_load_requester

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module l1d_load_requester

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TB_TOP) -o $(TB_TOP)
	set -o pipefail; ./obj_dir/$(TB_TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_l1d_load_requester.sv
`timescale 1ns/10ps

module tb_l1d_load_requester;

  localparam int PORTS = lrq_pkg::REQ_PORTS;
  localparam int NENT  = lrq_pkg::ENTRIES;

  logic                clk;
  logic                reset_n;
  lrq_pkg::port_oh_t   req_load;
  lrq_pkg::paddr_t     req_paddr [PORTS];
  lrq_pkg::port_oh_t   resp_full;
  lrq_pkg::port_oh_t   resp_conflict;
  lrq_pkg::entry_oh_t  resp_index_oh [PORTS];
  logic                ext_req_valid;
  logic                ext_req_ready;
  lrq_pkg::paddr_t     ext_req_addr;
  lrq_pkg::l2_tag_t    ext_req_tag;
  logic                ext_resp_valid;
  lrq_pkg::l2_tag_t    ext_resp_tag;
  lrq_pkg::line_t      ext_resp_data;
  logic                l1d_wr_valid;
  lrq_pkg::paddr_t     l1d_wr_paddr;
  lrq_pkg::line_t      l1d_wr_data;
  logic                resolve_valid;
  lrq_pkg::entry_oh_t  resolve_index_oh;

  // Model state codes are 0 idle, 1 wait send, 2 wait response, 3 fill ready and 4 done
  int                  m_state [NENT];
  int                  m_next [NENT];
  lrq_pkg::line_addr_t m_line [NENT];
  int                  m_in;
  int                  m_out;
  int                  m_free;
  logic                m_resp_vld;
  int                  m_resp_idx;
  logic                m_resolve_vld;
  lrq_pkg::entry_oh_t  m_resolve_oh;

  // Memory responder backlog
  int                  q_idx [$];
  int                  q_due [$];
  lrq_pkg::line_addr_t q_line [$];
  logic                d_resp_vld;
  int                  d_resp_idx;

  logic [31:0]         rng_state;
  int                  cycle_cnt;
  int                  loads_issued;
  int                  loads_taken;
  int                  lines_written;
  int                  strays_sent;
  int                  err_cnt;

  l1d_load_requester l1d_load_requester_inst (
    .i_clk              (clk),
    .i_reset_n          (reset_n),
    .i_req_load         (req_load),
    .i_req_paddr        (req_paddr),
    .o_resp_full        (resp_full),
    .o_resp_conflict    (resp_conflict),
    .o_resp_index_oh    (resp_index_oh),
    .o_ext_req_valid    (ext_req_valid),
    .i_ext_req_ready    (ext_req_ready),
    .o_ext_req_addr     (ext_req_addr),
    .o_ext_req_tag      (ext_req_tag),
    .i_ext_resp_valid   (ext_resp_valid),
    .i_ext_resp_tag     (ext_resp_tag),
    .i_ext_resp_data    (ext_resp_data),
    .o_l1d_wr_valid     (l1d_wr_valid),
    .o_l1d_wr_paddr     (l1d_wr_paddr),
    .o_l1d_wr_data      (l1d_wr_data),
    .o_resolve_valid    (resolve_valid),
    .o_resolve_index_oh (resolve_index_oh)
  );

  always #5 clk = ~clk;

  // Budget grows with every load driven
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 40 * loads_issued + 200) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic lrq_pkg::line_addr_t pool_line(int k);
    return 28'h0123400 + lrq_pkg::line_addr_t'(k) * 28'h0000105;
  endfunction

  // Memory contents as a function of the line address
  function automatic lrq_pkg::line_t line_data(lrq_pkg::line_addr_t l);
    logic [31:0] a;
    a = {l, 4'h0};
    return {a ^ 32'h9e3779b9, ~a, {a[15:0], a[31:16]}, a * 32'd2654435761};
  endfunction

  // First entry in a state searching from the out pointer
  function automatic int first_in_state(int st);
    int found;
    found = -1;
    for (int k = NENT - 1; k >= 0; k--) begin
      if (m_state[(m_out + k) % NENT] == st) begin
        found = (m_out + k) % NENT;
      end
    end
    return found;
  endfunction

  function automatic bit model_idle();
    bit idle;
    idle = (q_idx.size() == 0) && !m_resp_vld && !m_resolve_vld;
    for (int e = 0; e < NENT; e++) begin
      if (m_state[e] != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  // ------------------------------------------------------------
  // Stimulus and memory responder
  // ------------------------------------------------------------

  task automatic drive_inputs(input int load_pct, input int ready_pct);
    logic [31:0] r;
    int          hit;
    for (int p = 0; p < PORTS; p++) begin
      r            = lcg_next();
      req_load[p]  = (int'(r[31:24]) % 100) < load_pct;
      req_paddr[p] = {pool_line(int'(r[23:16]) % 6), r[3:0]};
      if (req_load[p]) begin
        loads_issued++;
      end
    end
    r             = lcg_next();
    ext_req_ready = (int'(r[31:24]) % 100) < ready_pct;
    hit = -1;
    for (int i = 0; i < q_idx.size(); i++) begin
      if (hit < 0 && q_due[i] <= cycle_cnt) begin
        hit = i;
      end
    end
    d_resp_vld     = 1'b0;
    ext_resp_valid = 1'b0;
    if (hit >= 0) begin
      ext_resp_valid = 1'b1;
      ext_resp_tag   = {2'b01, 4'b0000, 2'(q_idx[hit])};
      ext_resp_data  = line_data(q_line[hit]);
      d_resp_vld     = 1'b1;
      d_resp_idx     = q_idx[hit];
      q_idx.delete(hit);
      q_due.delete(hit);
      q_line.delete(hit);
    end else if (r[7:5] == 3'b000) begin
      // Stray response owned by another requester
      ext_resp_valid = 1'b1;
      ext_resp_tag   = {2'b10, 4'b0000, r[1:0]};
      ext_resp_data  = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      strays_sent++;
    end
  endtask

  // ------------------------------------------------------------
  // Checks against the model and the model step to the next edge
  // ------------------------------------------------------------

  task automatic check_and_update();
    lrq_pkg::line_addr_t ln [PORTS];
    lrq_pkg::entry_oh_t  exp_oh;
    logic                exp_conf;
    logic                exp_full;
    logic [31:0]         r;
    int                  rank;
    int                  taken;
    int                  pick;
    m_next = m_state;
    rank   = 0;
    taken  = 0;
    for (int p = 0; p < PORTS; p++) begin
      ln[p]    = req_paddr[p][lrq_pkg::PADDR_W-1:lrq_pkg::LINE_OFS_W];
      exp_oh   = '0;
      exp_conf = 1'b0;
      exp_full = 1'b0;
      if (req_load[p]) begin
        for (int e = 0; e < NENT; e++) begin
          if (m_state[e] != 0 && m_line[e] == ln[p]) begin
            exp_oh[e] = 1'b1;
            exp_conf  = 1'b1;
          end
        end
        for (int q = 0; q < p; q++) begin
          if (req_load[q] && ln[q] == ln[p]) begin
            exp_conf = 1'b1;
          end
        end
        if (!exp_conf && rank >= m_free) begin
          exp_full = 1'b1;
        end else if (!exp_conf) begin
          m_next[(m_in + rank) % NENT] = 1;
          m_line[(m_in + rank) % NENT] = ln[p];
          taken++;
        end
        rank = exp_conf ? rank : rank + 1;
      end
      if (req_load[p] && resp_conflict[p] === 1'b0 && resp_full[p] === 1'b0) begin
        loads_taken++;
      end
      if (resp_conflict[p] !== exp_conf || resp_full[p] !== exp_full ||
          resp_index_oh[p] !== exp_oh) begin
        report_mismatch($sformatf("port %0d conflict/full/index %b %b %b, expected %b %b %b",
                        p, resp_conflict[p], resp_full[p], resp_index_oh[p],
                        exp_conf, exp_full, exp_oh));
      end
    end
    m_in   = (m_in + taken) % NENT;
    m_free = m_free - taken;

    // External read of the oldest unsent entry
    pick = first_in_state(1);
    if (ext_req_valid !== (pick >= 0)) begin
      report_mismatch($sformatf("ext request valid %b, expected entry %0d", ext_req_valid, pick));
    end else if (pick >= 0) begin
      if (ext_req_tag !== {2'b01, 4'b0000, 2'(pick)} || ext_req_addr !== {m_line[pick], 4'h0}) begin
        report_mismatch($sformatf("ext request tag %h addr %h, expected entry %0d line %h",
                        ext_req_tag, ext_req_addr, pick, m_line[pick]));
      end
      if (ext_req_ready) begin
        r            = lcg_next();
        m_next[pick] = 2;
        q_idx.push_back(pick);
        q_line.push_back(m_line[pick]);
        q_due.push_back(cycle_cnt + 1 + int'(r[27:24]) % 12);
      end
    end

    // Registered response reaches its entry at this edge
    if (m_resp_vld) begin
      m_next[m_resp_idx] = 3;
    end
    m_resp_vld = d_resp_vld;
    m_resp_idx = d_resp_idx;

    pick = first_in_state(3);
    if (l1d_wr_valid === 1'b1) begin
      lines_written++;
    end
    if (l1d_wr_valid !== (pick >= 0)) begin
      report_mismatch($sformatf("L1D write valid %b, expected entry %0d", l1d_wr_valid, pick));
    end else if (pick >= 0) begin
      if (l1d_wr_paddr !== {m_line[pick], 4'h0} || l1d_wr_data !== line_data(m_line[pick])) begin
        report_mismatch($sformatf("L1D write addr %h data %h for entry %0d",
                        l1d_wr_paddr, l1d_wr_data, pick));
      end
      m_next[pick] = 4;
    end
    if (resolve_valid !== m_resolve_vld ||
        (m_resolve_vld && resolve_index_oh !== m_resolve_oh)) begin
      report_mismatch($sformatf("resolve %b index %b, expected %b index %b",
                      resolve_valid, resolve_index_oh, m_resolve_vld, m_resolve_oh));
    end
    m_resolve_vld = (pick >= 0);
    m_resolve_oh  = '0;
    if (pick >= 0) begin
      m_resolve_oh[pick] = 1'b1;
    end

    // Release in ring order
    if (m_state[m_out] == 4) begin
      m_next[m_out] = 0;
      m_out         = (m_out + 1) % NENT;
      m_free++;
    end
    m_state = m_next;
  endtask

  task automatic run_cycle(input int load_pct, input int ready_pct);
    @(negedge clk);
    drive_inputs(load_pct, ready_pct);
    #1;
    check_and_update();
  endtask

  task automatic run_test(input string name, input int cycles, input int load_pct,
                          input int ready_pct, input bit until_idle);
    int start_err;
    int n;
    start_err = err_cnt;
    n = 0;
    while (n < cycles || (until_idle && !model_idle())) begin
      run_cycle(load_pct, ready_pct);
      n++;
    end
    $display("test %s finished after %0d cycles with %0d errors", name, n, err_cnt - start_err);
  endtask

  // Distinct new lines with the grant held low until the ring runs full
  task automatic probe_capacity();
    int start_err;
    int start_taken;
    start_err   = err_cnt;
    start_taken = loads_taken;
    for (int c = 0; c <= NENT / PORTS; c++) begin
      @(negedge clk);
      for (int p = 0; p < PORTS; p++) begin
        req_load[p]  = 1'b1;
        req_paddr[p] = {28'h0abc000 + lrq_pkg::line_addr_t'(c * PORTS + p), 4'h0};
        loads_issued++;
      end
      ext_req_ready  = 1'b0;
      ext_resp_valid = 1'b0;
      d_resp_vld     = 1'b0;
      #1;
      check_and_update();
    end
    if (loads_taken - start_taken != NENT) begin
      report_mismatch($sformatf("%0d loads taken into the empty ring, expected %0d",
                      loads_taken - start_taken, NENT));
    end
    $display("test capacity finished after %0d cycles with %0d errors", NENT / PORTS + 1,
             err_cnt - start_err);
  endtask

  initial begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    req_load       = '0;
    req_paddr      = '{default: '0};
    ext_req_ready  = 1'b0;
    ext_resp_valid = 1'b0;
    ext_resp_tag   = '0;
    ext_resp_data  = '0;
    rng_state      = 32'd58819;
    cycle_cnt      = 0;
    loads_issued   = 0;
    loads_taken    = 0;
    lines_written  = 0;
    strays_sent    = 0;
    err_cnt        = 0;
    m_state        = '{default: 0};
    m_in           = 0;
    m_out          = 0;
    m_free         = NENT;
    m_resp_vld     = 1'b0;
    m_resp_idx     = 0;
    m_resolve_vld  = 1'b0;
    m_resolve_oh   = '0;
    d_resp_vld     = 1'b0;
    d_resp_idx     = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    run_test("random_traffic", 400, 45, 70, 1'b0);
    run_test("backpressure", 200, 60, 10, 1'b0);
    run_test("drain", 20, 0, 80, 1'b1);

    if (lines_written != loads_taken) begin
      report_mismatch($sformatf("%0d lines written for %0d taken loads",
                      lines_written, loads_taken));
    end

    probe_capacity();

    $display("loads issued %0d, taken %0d, lines written %0d, strays %0d, errors %0d",
             loads_issued, loads_taken, lines_written, strays_sent, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/l1d_load_requester.sv
`timescale 1ns/10ps

module l1d_load_requester (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Load pipelines
  input  lrq_pkg::port_oh_t   i_req_load,
  input  lrq_pkg::paddr_t     i_req_paddr [lrq_pkg::REQ_PORTS],
  output lrq_pkg::port_oh_t   o_resp_full,
  output lrq_pkg::port_oh_t   o_resp_conflict,
  output lrq_pkg::entry_oh_t  o_resp_index_oh [lrq_pkg::REQ_PORTS],

  // External read
  output logic                o_ext_req_valid,
  input  logic                i_ext_req_ready,
  output lrq_pkg::paddr_t     o_ext_req_addr,
  output lrq_pkg::l2_tag_t    o_ext_req_tag,

  input  logic                i_ext_resp_valid,
  input  lrq_pkg::l2_tag_t    i_ext_resp_tag,
  input  lrq_pkg::line_t      i_ext_resp_data,

  // L1D fill
  output logic                o_l1d_wr_valid,
  output lrq_pkg::paddr_t     o_l1d_wr_paddr,
  output lrq_pkg::line_t      o_l1d_wr_data,

  output logic                o_resolve_valid,
  output lrq_pkg::entry_oh_t  o_resolve_index_oh
);

  lrq_pkg::entry_oh_t  w_entry_valid;
  lrq_pkg::line_addr_t w_entry_line [lrq_pkg::ENTRIES];
  lrq_pkg::line_t      w_entry_data [lrq_pkg::ENTRIES];
  lrq_pkg::entry_oh_t  w_entry_done;
  lrq_pkg::entry_oh_t  w_send_ready;
  lrq_pkg::entry_oh_t  w_fill_ready;
  lrq_pkg::fill_rec_t  w_fill_rec [lrq_pkg::ENTRIES];

  lrq_pkg::entry_oh_t  w_load_oh;
  lrq_pkg::line_addr_t w_load_line [lrq_pkg::ENTRIES];
  lrq_pkg::entry_oh_t  w_clear_oh;
  lrq_pkg::entry_idx_t w_out_ptr;

  lrq_pkg::entry_oh_t  w_send_oh;
  lrq_pkg::line_addr_t w_send_line;
  lrq_pkg::entry_idx_t w_send_idx;
  logic                w_sent;

  lrq_pkg::entry_oh_t  w_resp_oh;
  lrq_pkg::line_t      w_resp_data;
  lrq_pkg::entry_oh_t  w_filled_oh;

  lrq_alloc u_alloc (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_req_load      (i_req_load),
    .i_req_paddr     (i_req_paddr),
    .i_entry_valid   (w_entry_valid),
    .i_entry_line    (w_entry_line),
    .i_entry_done    (w_entry_done),
    .o_resp_full     (o_resp_full),
    .o_resp_conflict (o_resp_conflict),
    .o_resp_index_oh (o_resp_index_oh),
    .o_load_oh       (w_load_oh),
    .o_load_line     (w_load_line),
    .o_clear_oh      (w_clear_oh),
    .o_out_ptr       (w_out_ptr)
  );

  for (genvar e = 0; e < lrq_pkg::ENTRIES; e++) begin : g_entry
    lrq_entry u_entry (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_load       (w_load_oh[e]),
      .i_load_line  (w_load_line[e]),
      .i_sent       (w_sent & w_send_oh[e]),
      .i_resp       (w_resp_oh[e]),
      .i_resp_data  (w_resp_data),
      .i_filled     (w_filled_oh[e]),
      .i_clear      (w_clear_oh[e]),
      .o_valid      (w_entry_valid[e]),
      .o_line       (w_entry_line[e]),
      .o_send_ready (w_send_ready[e]),
      .o_fill_ready (w_fill_ready[e]),
      .o_done       (w_entry_done[e]),
      .o_data       (w_entry_data[e])
    );

    assign w_fill_rec[e] = '{line: w_entry_line[e], data: w_entry_data[e]};
  end

  // ------------------------------------------------------------
  // External read request
  // ------------------------------------------------------------

  lrq_oldest_pick #(
    .T (lrq_pkg::line_addr_t)
  ) u_send_pick (
    .i_ready   (w_send_ready),
    .i_out_ptr (w_out_ptr),
    .i_payload (w_entry_line),
    .o_valid   (o_ext_req_valid),
    .o_pick_oh (w_send_oh),
    .o_payload (w_send_line)
  );

  always_comb begin
    w_send_idx = '0;
    for (int e = 0; e < lrq_pkg::ENTRIES; e++) begin
      if (w_send_oh[e]) begin
        w_send_idx = lrq_pkg::entry_idx_t'(e);
      end
    end
  end

  // Requester id on top, entry index at the bottom
  assign o_ext_req_tag = {lrq_pkg::TAG_UPPER_LRQ,
                          {(lrq_pkg::L2_TAG_W - $bits(lrq_pkg::TAG_UPPER_LRQ)
                            - lrq_pkg::ENTRY_IDX_W){1'b0}},
                          w_send_idx};
  assign o_ext_req_addr = {w_send_line, {lrq_pkg::LINE_OFS_W{1'b0}}};
  assign w_sent         = o_ext_req_valid & i_ext_req_ready;

  lrq_fill u_fill (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_ext_resp_valid   (i_ext_resp_valid),
    .i_ext_resp_tag     (i_ext_resp_tag),
    .i_ext_resp_data    (i_ext_resp_data),
    .i_fill_ready       (w_fill_ready),
    .i_fill_rec         (w_fill_rec),
    .i_out_ptr          (w_out_ptr),
    .o_resp_oh          (w_resp_oh),
    .o_resp_data        (w_resp_data),
    .o_filled_oh        (w_filled_oh),
    .o_l1d_wr_valid     (o_l1d_wr_valid),
    .o_l1d_wr_paddr     (o_l1d_wr_paddr),
    .o_l1d_wr_data      (o_l1d_wr_data),
    .o_resolve_valid    (o_resolve_valid),
    .o_resolve_index_oh (o_resolve_index_oh)
  );

endmodule

//--- source/lrq_fill.sv
`timescale 1ns/10ps

module lrq_fill (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_ext_resp_valid,
  input  lrq_pkg::l2_tag_t    i_ext_resp_tag,
  input  lrq_pkg::line_t      i_ext_resp_data,

  input  lrq_pkg::entry_oh_t  i_fill_ready,
  input  lrq_pkg::fill_rec_t  i_fill_rec [lrq_pkg::ENTRIES],
  input  lrq_pkg::entry_idx_t i_out_ptr,

  output lrq_pkg::entry_oh_t  o_resp_oh,
  output lrq_pkg::line_t      o_resp_data,
  output lrq_pkg::entry_oh_t  o_filled_oh,

  output logic                o_l1d_wr_valid,
  output lrq_pkg::paddr_t     o_l1d_wr_paddr,
  output lrq_pkg::line_t      o_l1d_wr_data,

  output logic                o_resolve_valid,
  output lrq_pkg::entry_oh_t  o_resolve_index_oh
);

  logic                r_resp_valid;
  lrq_pkg::entry_idx_t r_resp_idx;
  lrq_pkg::line_t      r_resp_data;
  lrq_pkg::fill_rec_t  w_fill_rec;

  // ------------------------------------------------------------
  // Response capture
  // ------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      // Other requesters share the response bus
      r_resp_valid <= i_ext_resp_valid &
                      (i_ext_resp_tag[lrq_pkg::L2_TAG_W-1 -: $bits(lrq_pkg::TAG_UPPER_LRQ)] ==
                       lrq_pkg::TAG_UPPER_LRQ);
    end
  end

  always_ff @(posedge i_clk) begin
    r_resp_idx  <= i_ext_resp_tag[lrq_pkg::ENTRY_IDX_W-1:0];
    r_resp_data <= i_ext_resp_data;
  end

  assign o_resp_oh   = r_resp_valid ? (lrq_pkg::entry_oh_t'(1) << r_resp_idx) : '0;
  assign o_resp_data = r_resp_data;

  // ------------------------------------------------------------
  // L1D write of the oldest fill-ready entry
  // ------------------------------------------------------------

  lrq_oldest_pick #(
    .T (lrq_pkg::fill_rec_t)
  ) u_fill_pick (
    .i_ready   (i_fill_ready),
    .i_out_ptr (i_out_ptr),
    .i_payload (i_fill_rec),
    .o_valid   (o_l1d_wr_valid),
    .o_pick_oh (o_filled_oh),
    .o_payload (w_fill_rec)
  );

  assign o_l1d_wr_paddr = {w_fill_rec.line, {lrq_pkg::LINE_OFS_W{1'b0}}};
  assign o_l1d_wr_data  = w_fill_rec.data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_resolve_valid    <= 1'b0;
      o_resolve_index_oh <= '0;
    end else begin
      o_resolve_valid    <= o_l1d_wr_valid;
      o_resolve_index_oh <= o_filled_oh;
    end
  end

  // The written entry has left fill-ready by the time it resolves
  a_write_resolves: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_l1d_wr_valid |=> o_resolve_valid && ((o_resolve_index_oh & i_fill_ready) == '0)
  );

endmodule

//--- source/lrq_oldest_pick.sv
`timescale 1ns/10ps

module lrq_oldest_pick #(
  parameter type T = lrq_pkg::line_addr_t
) (
  input  lrq_pkg::entry_oh_t  i_ready,
  input  lrq_pkg::entry_idx_t i_out_ptr,
  input  T                    i_payload [lrq_pkg::ENTRIES],

  output logic                o_valid,
  output lrq_pkg::entry_oh_t  o_pick_oh,
  output T                    o_payload
);

  // Search wraps around the ring starting at the oldest entry
  always_comb begin : search
    lrq_pkg::entry_idx_t idx;
    logic                found;
    found     = 1'b0;
    o_pick_oh = '0;
    for (int k = 0; k < lrq_pkg::ENTRIES; k++) begin
      idx = i_out_ptr + lrq_pkg::entry_idx_t'(k);
      if (!found && i_ready[idx]) begin
        o_pick_oh[idx] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  assign o_valid = |o_pick_oh;

  // One-hot OR select that gives zero when nothing is picked
  always_comb begin
    o_payload = '0;
    for (int e = 0; e < lrq_pkg::ENTRIES; e++) begin
      if (o_pick_oh[e]) begin
        o_payload = T'(o_payload | i_payload[e]);
      end
    end
  end

endmodule

//--- source/lrq_alloc.sv
`timescale 1ns/10ps

module lrq_alloc (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  lrq_pkg::port_oh_t   i_req_load,
  input  lrq_pkg::paddr_t     i_req_paddr [lrq_pkg::REQ_PORTS],

  input  lrq_pkg::entry_oh_t  i_entry_valid,
  input  lrq_pkg::line_addr_t i_entry_line [lrq_pkg::ENTRIES],
  input  lrq_pkg::entry_oh_t  i_entry_done,

  output lrq_pkg::port_oh_t   o_resp_full,
  output lrq_pkg::port_oh_t   o_resp_conflict,
  output lrq_pkg::entry_oh_t  o_resp_index_oh [lrq_pkg::REQ_PORTS],

  output lrq_pkg::entry_oh_t  o_load_oh,
  output lrq_pkg::line_addr_t o_load_line [lrq_pkg::ENTRIES],
  output lrq_pkg::entry_oh_t  o_clear_oh,
  output lrq_pkg::entry_idx_t o_out_ptr
);

  // Holds 0 to ENTRIES
  typedef logic [lrq_pkg::ENTRY_IDX_W:0] cnt_t;

  function automatic lrq_pkg::entry_oh_t rotl(lrq_pkg::entry_oh_t v, cnt_t n);
    logic [2*lrq_pkg::ENTRIES-1:0] w_dbl;
    w_dbl = {v, v} << n;
    return w_dbl[2*lrq_pkg::ENTRIES-1:lrq_pkg::ENTRIES];
  endfunction

  lrq_pkg::line_addr_t w_req_line [lrq_pkg::REQ_PORTS];
  lrq_pkg::entry_oh_t  w_hit_entry [lrq_pkg::REQ_PORTS];
  lrq_pkg::port_oh_t   w_hit_port;
  lrq_pkg::port_oh_t   w_no_conflict;
  lrq_pkg::port_oh_t   w_take;
  cnt_t                w_rank [lrq_pkg::REQ_PORTS];
  cnt_t                w_take_cnt;
  lrq_pkg::entry_oh_t  w_target [lrq_pkg::REQ_PORTS];
  logic                w_out_adv;

  lrq_pkg::entry_oh_t  r_in_ptr_oh;
  lrq_pkg::entry_oh_t  r_out_ptr_oh;
  cnt_t                r_free_cnt;

  // ------------------------------------------------------------
  // Conflict detection
  // ------------------------------------------------------------

  for (genvar p = 0; p < lrq_pkg::REQ_PORTS; p++) begin : g_port
    assign w_req_line[p] = i_req_paddr[p][lrq_pkg::PADDR_W-1:lrq_pkg::LINE_OFS_W];

    for (genvar e = 0; e < lrq_pkg::ENTRIES; e++) begin : g_cmp
      assign w_hit_entry[p][e] = i_req_load[p] & i_entry_valid[e] &
                                 (i_entry_line[e] == w_req_line[p]);
    end

    assign o_resp_conflict[p] = (|w_hit_entry[p]) | w_hit_port[p];
    assign o_resp_index_oh[p] = w_hit_entry[p];
    assign w_no_conflict[p]   = i_req_load[p] & ~o_resp_conflict[p];
    assign o_resp_full[p]     = w_no_conflict[p] & ~w_take[p];
    assign w_target[p]        = rotl(r_in_ptr_oh, w_rank[p]);

    // Lines in the ring are unique, so at most one entry can match
    a_index_onehot: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      $onehot0(o_resp_index_oh[p])
    );
  end

  // Same line from a lower port in this cycle
  always_comb begin
    for (int p = 0; p < lrq_pkg::REQ_PORTS; p++) begin
      w_hit_port[p] = 1'b0;
      for (int q = 0; q < p; q++) begin
        if (i_req_load[p] && i_req_load[q] && (w_req_line[p] == w_req_line[q])) begin
          w_hit_port[p] = 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Ranking against free entries
  // ------------------------------------------------------------

  always_comb begin : rank_calc
    cnt_t acc;
    acc        = '0;
    w_take_cnt = '0;
    for (int p = 0; p < lrq_pkg::REQ_PORTS; p++) begin
      w_rank[p] = acc;
      w_take[p] = w_no_conflict[p] & (acc < r_free_cnt);
      acc        = acc + cnt_t'(w_no_conflict[p]);
      w_take_cnt = w_take_cnt + cnt_t'(w_take[p]);
    end
  end

  // Taken ports land on consecutive entries from the in pointer
  always_comb begin
    o_load_oh = '0;
    for (int e = 0; e < lrq_pkg::ENTRIES; e++) begin
      o_load_line[e] = '0;
    end
    for (int p = 0; p < lrq_pkg::REQ_PORTS; p++) begin
      for (int e = 0; e < lrq_pkg::ENTRIES; e++) begin
        if (w_take[p] && w_target[p][e]) begin
          o_load_oh[e]   = 1'b1;
          o_load_line[e] = w_req_line[p];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Release in ring order
  // ------------------------------------------------------------

  assign o_clear_oh = i_entry_done & r_out_ptr_oh;
  assign w_out_adv  = |o_clear_oh;

  always_comb begin
    o_out_ptr = '0;
    for (int e = 0; e < lrq_pkg::ENTRIES; e++) begin
      if (r_out_ptr_oh[e]) begin
        o_out_ptr = lrq_pkg::entry_idx_t'(e);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh  <= lrq_pkg::entry_oh_t'(1);
      r_out_ptr_oh <= lrq_pkg::entry_oh_t'(1);
      r_free_cnt   <= cnt_t'(lrq_pkg::ENTRIES);
    end else begin
      r_in_ptr_oh  <= rotl(r_in_ptr_oh, w_take_cnt);
      if (w_out_adv) begin
        r_out_ptr_oh <= rotl(r_out_ptr_oh, cnt_t'(1));
      end
      r_free_cnt <= r_free_cnt - w_take_cnt + cnt_t'(w_out_adv);
    end
  end

endmodule

//--- source/lrq_entry.sv
`timescale 1ns/10ps

module lrq_entry (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_load,
  input  lrq_pkg::line_addr_t i_load_line,
  input  logic                i_sent,
  input  logic                i_resp,
  input  lrq_pkg::line_t      i_resp_data,
  input  logic                i_filled,
  input  logic                i_clear,

  output logic                o_valid,
  output lrq_pkg::line_addr_t o_line,
  output logic                o_send_ready,
  output logic                o_fill_ready,
  output logic                o_done,
  output lrq_pkg::line_t      o_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_SEND,
    ST_WAIT_RESP,
    ST_FILL_READY,
    ST_DONE
  } state_t;

  state_t              r_state;
  state_t              w_state_next;
  lrq_pkg::line_addr_t r_line;
  lrq_pkg::line_t      r_data;

  // Each step waits for its own strobe
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      ST_IDLE:       if (i_load)   w_state_next = ST_WAIT_SEND;
      ST_WAIT_SEND:  if (i_sent)   w_state_next = ST_WAIT_RESP;
      ST_WAIT_RESP:  if (i_resp)   w_state_next = ST_FILL_READY;
      ST_FILL_READY: if (i_filled) w_state_next = ST_DONE;
      ST_DONE:       if (i_clear)  w_state_next = ST_IDLE;
      default:                     w_state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  // Line address and returned data
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_line <= i_load_line;
    end
    if (i_resp && (r_state == ST_WAIT_RESP)) begin
      r_data <= i_resp_data;
    end
  end

  assign o_valid      = (r_state != ST_IDLE);
  assign o_line       = r_line;
  assign o_send_ready = (r_state == ST_WAIT_SEND);
  assign o_fill_ready = (r_state == ST_FILL_READY);
  assign o_done       = (r_state == ST_DONE);
  assign o_data       = r_data;

  // Allocator must only hand out idle entries
  a_load_idle: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_load |-> !o_valid
  );

endmodule

//--- source/lrq_pkg.sv
package lrq_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Load pipelines feeding the requester
  localparam int REQ_PORTS = 2;

  // Miss entries in the ring
  localparam int ENTRIES     = 4;
  localparam int ENTRY_IDX_W = $clog2(ENTRIES);

  localparam int PADDR_W    = 32;
  localparam int LINE_BYTES = 16;
  localparam int LINE_OFS_W = $clog2(LINE_BYTES);
  localparam int LINE_W     = LINE_BYTES * 8;

  // Top bits of the external bus tag name the requester
  localparam int L2_TAG_W = 8;
  localparam logic [1:0] TAG_UPPER_LRQ = 2'b01;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  typedef logic [PADDR_W-1:0] paddr_t;

  // Address without the offset inside the line
  typedef logic [PADDR_W-LINE_OFS_W-1:0] line_addr_t;

  typedef logic [LINE_W-1:0] line_t;

  typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;

  typedef logic [ENTRIES-1:0] entry_oh_t;

  typedef logic [REQ_PORTS-1:0] port_oh_t;

  typedef logic [L2_TAG_W-1:0] l2_tag_t;

  // What the fill path needs from one entry
  typedef struct packed {
    line_addr_t line;
    line_t      data;
  } fill_rec_t;

endpackage
